// File: verilog/cpuControlPkg.sv
`default_nettype none

package cpuControlPkg;

    ////////////////////
    // Widths

    localparam int instrWidth    = 16;
    localparam int dataWidth     = 16;
    localparam int regIndexWidth = 4;
    localparam int aluOpWidth    = 4;
    localparam int pcStepWidth   = 8;
    localparam int psrWidth      = 5;

    typedef logic [instrWidth-1:0]           instrT;
    typedef logic [dataWidth-1:0]            dataWordT;
    typedef logic [regIndexWidth-1:0]        regIndexT;
    // Also carries the ALU extension field
    typedef logic [aluOpWidth-1:0]           aluOpT;
    // Relative PC step, two's complement
    typedef logic signed [pcStepWidth-1:0]   pcStepT;
    typedef logic [psrWidth-1:0]             psrT;

    // ALU second operand source
    typedef enum logic [1:0] {
        selImmediate = 2'd0,
        selRegA      = 2'd1,
        selMemory    = 2'd2,
        selPc        = 2'd3
    } aluSrcT;

    // How the 8-bit immediate field lands in the 16-bit word
    typedef enum logic [2:0] {
        none,
        signExt,
        zeroExt,
        upper,
        unknown
    } immKindT;

    ////////////////////
    // Major opcodes in INS[15:12]

    localparam aluOpT opRegAlu  = 4'd0;
    localparam aluOpT opBranch  = 4'd1;
    localparam aluOpT opCmp     = 4'd3;
    localparam aluOpT opMemory  = 4'd4;
    localparam aluOpT opAddi    = 4'd5;
    localparam aluOpT opAddui   = 4'd6;
    localparam aluOpT opMoviu   = 4'd7;
    localparam aluOpT opMovi    = 4'd8;
    localparam aluOpT opSubi    = 4'd9;
    localparam aluOpT opJumpRel = 4'd10;
    localparam aluOpT opCmpi    = 4'd11;
    localparam aluOpT opJumpReg = 4'd12;

    ////////////////////
    // Sub-codes in INS[11:8]

    localparam logic [3:0] condGe       = 4'd0;
    localparam logic [3:0] condHs       = 4'd1;
    localparam logic [3:0] condEq       = 4'd2;
    localparam logic [3:0] condLt       = 4'd3;
    localparam logic [3:0] condLs       = 4'd4;
    // Relative jump only
    localparam logic [3:0] condAlways   = 4'd5;
    localparam logic [3:0] memLoad      = 4'd0;
    localparam logic [3:0] memStore     = 4'd1;
    localparam logic [3:0] jumpRegister = 4'd0;
    localparam logic [3:0] storePc      = 4'd1;

    // ALU move, issued with opcode zero
    localparam aluOpT aluExtMove = 4'd13;

    // Status flag positions
    localparam int psrGreaterBit = 0;
    localparam int psrZeroBit    = 1;
    localparam int psrHigherBit  = 3;

    // Fixed PC steps
    localparam pcStepT pcStepNext = 8'sd1;
    localparam pcStepT pcStepSkip = 8'sd2;
    localparam pcStepT pcStepHold = 8'sd0;

    localparam logic [7:0] unknownFill = 8'hFF;

endpackage

`default_nettype wire

// File: verilog/instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  cpuControlPkg::instrT    Ins,
    output cpuControlPkg::aluOpT    OpCode,
    output cpuControlPkg::aluOpT    OpExt,
    output logic                    RegWrite,
    output cpuControlPkg::regIndexT RegIn,
    output cpuControlPkg::regIndexT RegA,
    output cpuControlPkg::regIndexT RegB,
    output cpuControlPkg::aluSrcT   SelAlu,
    output logic                    MemRw,
    output logic                    IrWrite,
    output logic                    PcWrite,
    output logic                    PcIncrement,
    output cpuControlPkg::immKindT  immKind
);
    import cpuControlPkg::*;

    // Instruction fields
    aluOpT      major;
    logic [3:0] sub;
    regIndexT   fieldA;
    regIndexT   fieldB;

    assign major  = Ins[15:12];
    assign sub    = Ins[11:8];
    assign fieldA = Ins[7:4];
    assign fieldB = Ins[3:0];

    always_comb
    begin
        // Fallback for unknown opcodes and sub-codes
        OpCode      = '0;
        OpExt       = '0;
        RegWrite    = 1'b0;
        RegIn       = '0;
        RegA        = '0;
        RegB        = '0;
        SelAlu      = selImmediate;
        MemRw       = 1'b0;
        IrWrite     = 1'b0;
        PcWrite     = 1'b0;
        PcIncrement = 1'b1;
        immKind     = unknown;

        case (major)
            opRegAlu, opCmp:
            begin
                // Register to register, CMP only sets flags
                OpCode   = major;
                OpExt    = sub;
                RegWrite = (major == opRegAlu);
                RegIn    = (major == opRegAlu) ? fieldB : '0;
                RegA     = fieldA;
                RegB     = fieldB;
                SelAlu   = selRegA;
                immKind  = none;
            end
            opAddi, opAddui, opMoviu, opMovi, opSubi:
            begin
                OpCode   = major;
                OpExt    = sub;
                RegWrite = 1'b1;
                RegIn    = fieldB;
                RegB     = fieldB;
                if (major == opAddi || major == opSubi)
                    immKind = signExt;
                else
                    immKind = (major == opMoviu) ? upper : zeroExt;
            end
            opCmpi:
            begin
                OpCode  = major;
                OpExt   = sub;
                RegA    = fieldA;
                RegB    = fieldB;
                immKind = signExt;
            end
            opBranch, opJumpRel:
            begin
                // Step comes from the branch resolver, nothing is written
                if (sub <= condLs || (major == opJumpRel && sub == condAlways))
                begin
                    SelAlu  = selRegA;
                    immKind = none;
                end
            end
            opMemory:
            begin
                OpExt = aluExtMove;
                RegB  = fieldA;
                if (sub == memLoad)
                begin
                    RegWrite = 1'b1;
                    RegIn    = fieldB;
                    SelAlu   = selMemory;
                    immKind  = none;
                end
                else if (sub == memStore)
                begin
                    // Write data from A, address from B
                    RegA    = fieldB;
                    SelAlu  = selRegA;
                    MemRw   = 1'b1;
                    IrWrite = 1'b1;
                    immKind = none;
                end
                else
                begin
                    OpExt = '0;
                    RegB  = '0;
                end
            end
            opJumpReg:
            begin
                if (sub == jumpRegister)
                begin
                    // Move A straight into the PC
                    OpExt       = aluExtMove;
                    RegA        = fieldA;
                    SelAlu      = selRegA;
                    PcWrite     = 1'b1;
                    PcIncrement = 1'b0;
                    immKind     = none;
                end
                else if (sub == storePc)
                begin
                    OpExt    = aluExtMove;
                    RegWrite = 1'b1;
                    RegIn    = fieldB;
                    SelAlu   = selPc;
                    immKind  = none;
                end
            end
            default:
            begin
                // Keep the fallback decode
            end
        endcase
    end

    // A store never writes back into the register file
    storeNoRegWrite: assert final (!(MemRw && RegWrite))
        else $error("MemRw and RegWrite high together");

endmodule

`default_nettype wire

// File: verilog/immediateGenerator.sv
`timescale 1ns/1ps
`default_nettype none

module immediateGenerator (
    input  cpuControlPkg::instrT    Ins,
    input  cpuControlPkg::immKindT  immKind,
    output cpuControlPkg::dataWordT rawImmediate
);
    import cpuControlPkg::*;

    // 8-bit immediate field of the instruction
    logic [7:0] immField;

    assign immField = Ins[11:4];

    always_comb
    begin
        case (immKind)
            signExt:
            begin
                rawImmediate = {{8{immField[7]}}, immField};
            end
            zeroExt:
            begin
                rawImmediate = {8'h00, immField};
            end
            upper:
            begin
                // MOVIU, low byte comes later from MOVI or ADDUI
                rawImmediate = {immField, 8'h00};
            end
            unknown:
            begin
                rawImmediate = {unknownFill, immField};
            end
            default:
            begin
                // No immediate in use
                rawImmediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/branchResolver.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolver (
    input  cpuControlPkg::instrT  Ins,
    input  cpuControlPkg::psrT    Psr,
    output cpuControlPkg::pcStepT rawPcStep
);
    import cpuControlPkg::*;

    logic condKnown;
    logic condTrue;
    logic flagG;
    logic flagZ;
    logic flagH;

    assign flagG = Psr[psrGreaterBit];
    assign flagZ = Psr[psrZeroBit];
    assign flagH = Psr[psrHigherBit];

    ////////////////////
    // Condition evaluation

    always_comb
    begin
        condKnown = 1'b1;
        case (Ins[11:8])
            condGe:     condTrue = flagZ | flagG;
            condHs:     condTrue = flagH | flagZ;
            condEq:     condTrue = flagZ;
            condLt:     condTrue = ~(flagZ | flagG);
            condLs:     condTrue = ~flagH;
            // Only legal on a relative jump
            condAlways: condTrue = (Ins[15:12] == opJumpRel);
            default:
            begin
                condKnown = 1'b0;
                condTrue  = 1'b0;
            end
        endcase
    end

    ////////////////////
    // PC step selection

    always_comb
    begin
        rawPcStep = pcStepNext;
        if (Ins[15:12] == opBranch && condKnown && Ins[11:8] != condAlways)
        begin
            // Skip the next word when the condition fails
            rawPcStep = condTrue ? pcStepNext : pcStepSkip;
        end
        else if (Ins[15:12] == opJumpRel && condKnown)
        begin
            rawPcStep = condTrue ? pcStepT'(Ins[7:0]) : pcStepNext;
        end
        else if (Ins[15:12] == opJumpReg && Ins[11:8] == jumpRegister)
        begin
            // PC is loaded from the ALU instead
            rawPcStep = pcStepHold;
        end
    end

endmodule

`default_nettype wire

// File: verilog/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
    input  logic                    Clock,
    input  logic                    Reset,
    // Decoded execute values
    input  cpuControlPkg::aluOpT    rawOpCode,
    input  cpuControlPkg::aluOpT    rawOpExt,
    input  logic                    rawRegWrite,
    input  cpuControlPkg::regIndexT rawRegIn,
    input  cpuControlPkg::regIndexT rawRegA,
    input  cpuControlPkg::regIndexT rawRegB,
    input  cpuControlPkg::dataWordT rawImmediate,
    input  cpuControlPkg::pcStepT   rawPcStep,
    input  cpuControlPkg::aluSrcT   rawSelAlu,
    input  logic                    rawMemRw,
    input  logic                    rawIrWrite,
    input  logic                    rawPcWrite,
    input  logic                    rawPcIncrement,
    // Controller outputs
    output cpuControlPkg::aluOpT    OpCode,
    output cpuControlPkg::aluOpT    OpExt,
    output logic                    RegWrite,
    output cpuControlPkg::regIndexT RegIn,
    output cpuControlPkg::regIndexT RegA,
    output cpuControlPkg::regIndexT RegB,
    output cpuControlPkg::dataWordT Immediate,
    output cpuControlPkg::pcStepT   PcImmediate,
    output cpuControlPkg::aluSrcT   SelAlu,
    output logic                    SelMem,
    output logic                    MemRw,
    output logic                    PcWrite,
    output logic                    PcIncrement,
    output logic                    IrWrite,
    output logic                    PsrEnable
);
    import cpuControlPkg::*;

    // Low in fetch, high in execute
    logic executePhase;

    always_ff @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
            executePhase <= 1'b0;
        else
            executePhase <= ~executePhase;
    end

    always_comb
    begin
        // Everything idle while in reset
        OpCode      = '0;
        OpExt       = '0;
        RegWrite    = 1'b0;
        RegIn       = '0;
        RegA        = '0;
        RegB        = '0;
        Immediate   = '0;
        PcImmediate = '0;
        SelAlu      = selImmediate;
        SelMem      = 1'b0;
        MemRw       = 1'b0;
        PcWrite     = 1'b0;
        PcIncrement = 1'b0;
        IrWrite     = 1'b0;
        PsrEnable   = 1'b0;

        if (Reset && !executePhase)
        begin
            // Fetch, PC addresses memory and IR loads the word
            SelMem  = 1'b1;
            IrWrite = 1'b1;
        end
        else if (Reset)
        begin
            OpCode      = rawOpCode;
            OpExt       = rawOpExt;
            RegWrite    = rawRegWrite;
            RegIn       = rawRegIn;
            RegA        = rawRegA;
            RegB        = rawRegB;
            Immediate   = rawImmediate;
            PcImmediate = rawPcStep;
            SelAlu      = rawSelAlu;
            MemRw       = rawMemRw;
            PcWrite     = rawPcWrite;
            PcIncrement = rawPcIncrement;
            IrWrite     = rawIrWrite;
            // Flags update on every execute
            PsrEnable   = 1'b1;
        end
    end

    // Fetch and execute strictly alternate out of reset
    phaseToggles: assert property (@(posedge Clock) disable iff (!Reset)
        $past(Reset) |-> (executePhase != $past(executePhase)))
        else $error("Phase did not toggle");

endmodule

`default_nettype wire

// File: verilog/cpuController.sv
`timescale 1ns/1ps
`default_nettype none

module cpuController (
    input  logic                    Clock,
    input  logic                    Reset,
    input  cpuControlPkg::instrT    Ins,
    input  cpuControlPkg::psrT      Psr,
    output cpuControlPkg::aluOpT    OpCode,
    output cpuControlPkg::aluOpT    OpExt,
    output logic                    RegWrite,
    output cpuControlPkg::regIndexT RegIn,
    output cpuControlPkg::regIndexT RegA,
    output cpuControlPkg::regIndexT RegB,
    output cpuControlPkg::dataWordT Immediate,
    output cpuControlPkg::pcStepT   PcImmediate,
    output cpuControlPkg::aluSrcT   SelAlu,
    output logic                    SelMem,
    output logic                    MemRw,
    output logic                    PcWrite,
    output logic                    PcIncrement,
    output logic                    IrWrite,
    output logic                    PsrEnable
);
    import cpuControlPkg::*;

    // Execute-phase decode, before phase gating
    aluOpT    rawOpCode;
    aluOpT    rawOpExt;
    logic     rawRegWrite;
    regIndexT rawRegIn;
    regIndexT rawRegA;
    regIndexT rawRegB;
    aluSrcT   rawSelAlu;
    logic     rawMemRw;
    logic     rawIrWrite;
    logic     rawPcWrite;
    logic     rawPcIncrement;
    immKindT  immKind;
    dataWordT rawImmediate;
    pcStepT   rawPcStep;

    instructionDecoder decoder (
        .Ins         (Ins),
        .OpCode      (rawOpCode),
        .OpExt       (rawOpExt),
        .RegWrite    (rawRegWrite),
        .RegIn       (rawRegIn),
        .RegA        (rawRegA),
        .RegB        (rawRegB),
        .SelAlu      (rawSelAlu),
        .MemRw       (rawMemRw),
        .IrWrite     (rawIrWrite),
        .PcWrite     (rawPcWrite),
        .PcIncrement (rawPcIncrement),
        .immKind     (immKind)
    );

    immediateGenerator immGen (
        .Ins          (Ins),
        .immKind      (immKind),
        .rawImmediate (rawImmediate)
    );

    branchResolver branch (
        .Ins       (Ins),
        .Psr       (Psr),
        .rawPcStep (rawPcStep)
    );

    phaseSequencer sequencer (
        .Clock          (Clock),
        .Reset          (Reset),
        .rawOpCode      (rawOpCode),
        .rawOpExt       (rawOpExt),
        .rawRegWrite    (rawRegWrite),
        .rawRegIn       (rawRegIn),
        .rawRegA        (rawRegA),
        .rawRegB        (rawRegB),
        .rawImmediate   (rawImmediate),
        .rawPcStep      (rawPcStep),
        .rawSelAlu      (rawSelAlu),
        .rawMemRw       (rawMemRw),
        .rawIrWrite     (rawIrWrite),
        .rawPcWrite     (rawPcWrite),
        .rawPcIncrement (rawPcIncrement),
        .OpCode         (OpCode),
        .OpExt          (OpExt),
        .RegWrite       (RegWrite),
        .RegIn          (RegIn),
        .RegA           (RegA),
        .RegB           (RegB),
        .Immediate      (Immediate),
        .PcImmediate    (PcImmediate),
        .SelAlu         (SelAlu),
        .SelMem         (SelMem),
        .MemRw          (MemRw),
        .PcWrite        (PcWrite),
        .PcIncrement    (PcIncrement),
        .IrWrite        (IrWrite),
        .PsrEnable      (PsrEnable)
    );

endmodule

`default_nettype wire

// File: bench/cpuControllerTests.svh
`ifndef CPU_CONTROLLER_TESTS_SVH
`define CPU_CONTROLLER_TESTS_SVH

// Outputs zero in reset, then fetch and execute alternate
task automatic testResetAndPhase();
    repeat (10)
        applyAndCheck("reset", instrT'($urandom), psrT'($urandom));
    @(posedge Clock);
    Reset <= 1'b1;
    // First cycle after release is fetch
    @(negedge Clock);
    lastExecute = edgesSinceRelease[0];
    computeExpected(Reset, lastExecute, Ins, Psr);
    checkOutputs("release");
    repeat (16)
        applyAndCheck("phase", instrT'($urandom), psrT'($urandom));
endtask

// Register ALU, CMP, CMPI and the immediate group
task automatic testRegisterAndImmediate();
    aluOpT immOps [0:4] = '{opAddi, opAddui, opMoviu, opMovi, opSubi};
    repeat (12)
    begin
        executeCheck("regAlu", {opRegAlu, 12'($urandom)}, psrT'($urandom));
        executeCheck("cmp", {opCmp, 12'($urandom)}, psrT'($urandom));
        executeCheck("cmpi", {opCmpi, 12'($urandom)}, psrT'($urandom));
    end
    foreach (immOps[i])
        repeat (6)
            executeCheck("immediate", {immOps[i], 12'($urandom)}, psrT'($urandom));
endtask

// Every skip condition against every status word
task automatic testSkipBranches();
    for (int c = condGe; c <= condLs; c++)
        for (int p = 0; p < 32; p++)
            executeCheck("skipBranch", {opBranch, 4'(c), 8'($urandom)}, psrT'(p));
endtask

// Relative jumps, register jump and store-PC
task automatic testJumps();
    string name;
    for (int c = condGe; c <= condAlways; c++)
    begin
        name = (c == condAlways) ? "jumpAlways" : "jumpRel";
        // Random offset, including negative ones
        for (int p = 0; p < 32; p++)
            executeCheck(name, {opJumpRel, 4'(c), 8'($urandom)}, psrT'(p));
    end
    repeat (8)
    begin
        executeCheck("jumpReg", {opJumpReg, jumpRegister, 8'($urandom)}, psrT'($urandom));
        executeCheck("storePc", {opJumpReg, storePc, 8'($urandom)}, psrT'($urandom));
    end
endtask

// Load, store and the opcodes without a meaning
task automatic testMemoryAndUnknown();
    aluOpT unknownOps [0:3] = '{4'd2, 4'd13, 4'd14, 4'd15};
    repeat (8)
    begin
        executeCheck("load", {opMemory, memLoad, 8'($urandom)}, psrT'($urandom));
        executeCheck("store", {opMemory, memStore, 8'($urandom)}, psrT'($urandom));
    end
    foreach (unknownOps[i])
        repeat (6)
            executeCheck("unknownOp", {unknownOps[i], 12'($urandom)}, psrT'($urandom));
endtask

`endif

// File: bench/cpuControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControllerTb;
    import cpuControlPkg::*;

    localparam int clockPeriod = 100;
    // Tests take about a thousand cycles, so allow three times that
    localparam int watchdogCycles = 3000;

    logic     Clock;
    logic     Reset;
    instrT    Ins;
    psrT      Psr;
    aluOpT    OpCode;
    aluOpT    OpExt;
    logic     RegWrite;
    regIndexT RegIn;
    regIndexT RegA;
    regIndexT RegB;
    dataWordT Immediate;
    pcStepT   PcImmediate;
    aluSrcT   SelAlu;
    logic     SelMem;
    logic     MemRw;
    logic     PcWrite;
    logic     PcIncrement;
    logic     IrWrite;
    logic     PsrEnable;

    // Reference model results
    aluOpT    expOpCode;
    aluOpT    expOpExt;
    logic     expRegWrite;
    regIndexT expRegIn;
    regIndexT expRegA;
    regIndexT expRegB;
    dataWordT expImmediate;
    pcStepT   expPcStep;
    aluSrcT   expSelAlu;
    logic     expSelMem;
    logic     expMemRw;
    logic     expPcWrite;
    logic     expPcIncrement;
    logic     expIrWrite;
    logic     expPsrEnable;

    int          errorCount = 0;
    // Odd count means execute
    int          edgesSinceRelease = 0;
    logic        lastExecute;

    cpuController UUT (.*);

    ////////////////////
    // Clock, watchdog and phase tracking

    initial
    begin
        Clock = 1'b0;
        forever #(clockPeriod / 2) Clock = ~Clock;
    end

    initial
    begin
        #(watchdogCycles * clockPeriod);
        $display("Timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
        $display("Summary: %0d errors", errorCount);
        $display("Testbench failed");
        $finish;
    end

    // Release edge itself still sees reset, so the first cycle is fetch
    always @(posedge Clock or negedge Reset)
    begin
        if (!Reset)
            edgesSinceRelease <= 0;
        else
            edgesSinceRelease <= edgesSinceRelease + 1;
    end

    ////////////////////
    // Compare tasks

    task automatic reportMismatch(input string testName, input string signal,
                                  input string expected, input string actual);
        $display("CHECK FAILED %s %s: expected %s, actual %s", testName, signal, expected, actual);
        errorCount++;
    endtask

    task automatic checkAluOp(input string testName, input string signal,
                              input aluOpT expected, input aluOpT actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkRegIndex(input string testName, input string signal,
                                 input regIndexT expected, input regIndexT actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkDataWord(input string testName, input string signal,
                                 input dataWordT expected, input dataWordT actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%h", expected), $sformatf("%h", actual));
    endtask

    task automatic checkPcStep(input string testName, input string signal,
                               input pcStepT expected, input pcStepT actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%0d", expected),
                           $sformatf("%0d", actual));
    endtask

    task automatic checkAluSrc(input string testName, input string signal,
                               input aluSrcT expected, input aluSrcT actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%0d", expected),
                           $sformatf("%0d", actual));
    endtask

    task automatic checkBit(input string testName, input string signal,
                            input logic expected, input logic actual);
        if (actual !== expected)
            reportMismatch(testName, signal, $sformatf("%b", expected), $sformatf("%b", actual));
    endtask

    task automatic checkOutputs(input string testName);
        checkAluOp(testName, "OpCode", expOpCode, OpCode);
        checkAluOp(testName, "OpExt", expOpExt, OpExt);
        checkBit(testName, "RegWrite", expRegWrite, RegWrite);
        checkRegIndex(testName, "RegIn", expRegIn, RegIn);
        checkRegIndex(testName, "RegA", expRegA, RegA);
        checkRegIndex(testName, "RegB", expRegB, RegB);
        checkDataWord(testName, "Immediate", expImmediate, Immediate);
        checkPcStep(testName, "PcImmediate", expPcStep, PcImmediate);
        checkAluSrc(testName, "SelAlu", expSelAlu, SelAlu);
        checkBit(testName, "SelMem", expSelMem, SelMem);
        checkBit(testName, "MemRw", expMemRw, MemRw);
        checkBit(testName, "PcWrite", expPcWrite, PcWrite);
        checkBit(testName, "PcIncrement", expPcIncrement, PcIncrement);
        checkBit(testName, "IrWrite", expIrWrite, IrWrite);
        checkBit(testName, "PsrEnable", expPsrEnable, PsrEnable);
    endtask

    ////////////////////
    // Reference model

    // Branch condition against the status flags
    function automatic logic condHolds(input logic [3:0] cond, input psrT psr);
        logic g;
        logic z;
        logic h;
        g = psr[psrGreaterBit];
        z = psr[psrZeroBit];
        h = psr[psrHigherBit];
        case (cond)
            condGe:     return z || g;
            condHs:     return h || z;
            condEq:     return z;
            condLt:     return !z && !g;
            condLs:     return !h;
            condAlways: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic computeExpected(input logic released, input logic execute,
                                   input instrT ins, input psrT psr);
        logic [3:0] major;
        logic [3:0] sub;
        logic       known;
        major          = ins[15:12];
        sub            = ins[11:8];
        known          = 1'b1;
        // Reset values, also the base for fetch and execute
        expOpCode      = '0;
        expOpExt       = '0;
        expRegWrite    = 1'b0;
        expRegIn       = '0;
        expRegA        = '0;
        expRegB        = '0;
        expImmediate   = '0;
        expPcStep      = '0;
        expSelAlu      = selImmediate;
        expSelMem      = 1'b0;
        expMemRw       = 1'b0;
        expPcWrite     = 1'b0;
        expPcIncrement = 1'b0;
        expIrWrite     = 1'b0;
        expPsrEnable   = 1'b0;
        if (released && !execute)
        begin
            // Fetch ignores the instruction
            expIrWrite = 1'b1;
            expSelMem  = 1'b1;
        end
        else if (released)
        begin
            expPsrEnable   = 1'b1;
            expPcIncrement = 1'b1;
            expPcStep      = pcStepNext;
            case (major)
                opRegAlu, opCmp:
                begin
                    expOpCode = major;
                    expOpExt  = sub;
                    expRegA   = ins[7:4];
                    expRegB   = ins[3:0];
                    expSelAlu = selRegA;
                    if (major == opRegAlu)
                    begin
                        expRegWrite = 1'b1;
                        expRegIn    = ins[3:0];
                    end
                end
                opAddi, opAddui, opMoviu, opMovi, opSubi, opCmpi:
                begin
                    expOpCode = major;
                    expOpExt  = sub;
                    expRegB   = ins[3:0];
                    // CMPI reads A and writes nothing
                    if (major == opCmpi)
                        expRegA = ins[7:4];
                    else
                    begin
                        expRegWrite = 1'b1;
                        expRegIn    = ins[3:0];
                    end
                    if (major == opMoviu)
                        expImmediate = {ins[11:4], 8'h00};
                    else if (major == opAddui || major == opMovi)
                        expImmediate = {8'h00, ins[11:4]};
                    else
                        expImmediate = {{8{ins[11]}}, ins[11:4]};
                end
                opBranch:
                begin
                    known = (sub <= condLs);
                    if (known)
                    begin
                        expSelAlu = selRegA;
                        expPcStep = condHolds(sub, psr) ? pcStepNext : pcStepSkip;
                    end
                end
                opJumpRel:
                begin
                    known = (sub <= condAlways);
                    if (known)
                    begin
                        expSelAlu = selRegA;
                        expPcStep = condHolds(sub, psr) ? pcStepT'(ins[7:0]) : pcStepNext;
                    end
                end
                opMemory:
                begin
                    known = (sub == memLoad || sub == memStore);
                    if (sub == memLoad)
                    begin
                        expOpExt    = aluExtMove;
                        expRegB     = ins[7:4];
                        expRegWrite = 1'b1;
                        expRegIn    = ins[3:0];
                        expSelAlu   = selMemory;
                    end
                    else if (sub == memStore)
                    begin
                        expOpExt   = aluExtMove;
                        expRegB    = ins[7:4];
                        expRegA    = ins[3:0];
                        expSelAlu  = selRegA;
                        expMemRw   = 1'b1;
                        expIrWrite = 1'b1;
                    end
                end
                opJumpReg:
                begin
                    known = (sub == jumpRegister || sub == storePc);
                    if (sub == jumpRegister)
                    begin
                        expOpExt       = aluExtMove;
                        expRegA        = ins[7:4];
                        expSelAlu      = selRegA;
                        expPcWrite     = 1'b1;
                        expPcIncrement = 1'b0;
                        expPcStep      = pcStepHold;
                    end
                    else if (sub == storePc)
                    begin
                        expOpExt    = aluExtMove;
                        expRegWrite = 1'b1;
                        expRegIn    = ins[3:0];
                        expSelAlu   = selPc;
                    end
                end
                default:
                begin
                    known = 1'b0;
                end
            endcase
            // Unknown opcode or sub-code
            if (!known)
                expImmediate = {unknownFill, ins[11:4]};
        end
    endtask

    ////////////////////
    // Stimulus helpers

    // Drive on the rising edge, check mid-cycle
    task automatic applyAndCheck(input string testName, input instrT ins, input psrT psr);
        @(posedge Clock);
        Ins <= ins;
        Psr <= psr;
        @(negedge Clock);
        lastExecute = edgesSinceRelease[0];
        computeExpected(Reset, lastExecute, Ins, Psr);
        checkOutputs(testName);
    endtask

    // Holds the instruction until an execute cycle has been checked
    task automatic executeCheck(input string testName, input instrT ins, input psrT psr);
        applyAndCheck(testName, ins, psr);
        if (!lastExecute)
            applyAndCheck(testName, ins, psr);
    endtask

    `include "cpuControllerTests.svh"

    initial
    begin
        void'($urandom(32'h4469_72c0));
        Reset     = 1'b0;
        Ins       = '0;
        Psr       = '0;
        testResetAndPhase();
        testRegisterAndImmediate();
        testSkipBranches();
        testJumps();
        testMemoryAndUnknown();
        $display("Summary: %0d errors", errorCount);
        if (errorCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
verilog/cpuControlPkg.sv
verilog/instructionDecoder.sv
verilog/immediateGenerator.sv
verilog/branchResolver.sv
verilog/phaseSequencer.sv
verilog/cpuController.sv
bench/cpuControllerTb.sv

// File: Bender.yml
package:
  name: cpu_controller

sources:
  - verilog/cpuControlPkg.sv
  - verilog/instructionDecoder.sv
  - verilog/immediateGenerator.sv
  - verilog/branchResolver.sv
  - verilog/phaseSequencer.sv
  - verilog/cpuController.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/cpuControllerTb.sv
